/* verilog/bconv_pkg.sv */
// shared widths, memory map constants and bus structs, referenced by scoped name
`default_nettype none

package bconv_pkg;

	// memory geometry
	localparam int addr_width = 12;
	localparam int word_width = 16;

	// fixed 3x3 kernel and vote threshold
	localparam int kernel_size = 3;
	localparam int match_threshold = 5;

	typedef logic [addr_width-1:0] addr_t;
	typedef logic [word_width-1:0] word_t;
	typedef logic [$clog2(word_width)-1:0] col_idx_t;
	typedef logic [kernel_size*kernel_size-1:0] kernel_t;

	// row count value that ends a run
	localparam word_t end_marker = 16'h00FF;
	// kernel word lives here, address 0 unused
	localparam addr_t weight_addr = 12'd1;

	// ====================
	// fetcher to buffer, one strobe at a time
	typedef struct packed {
		logic load;
		logic shift;
		word_t row0;
		word_t row1;
		word_t row2;
	} row_set_t;

	// one column of three window rows, bit 0 is the top row
	typedef struct packed {
		logic valid;
		logic [kernel_size-1:0] bits;
		col_idx_t col;
		logic last;
		logic flush;
	} window_col_t;

	// one output bit with its column
	typedef struct packed {
		logic valid;
		logic hit;
		col_idx_t col;
		logic row_end;
	} vote_t;

	typedef struct packed {
		logic enable;
		addr_t address;
		word_t data;
	} sram_write_t;

endpackage

`default_nettype wire

/* verilog/row_fetcher.sv */
// producer of the engine, walks the input memory image by image and feeds rows to the buffer
`timescale 1ns/10ps
`default_nettype none

module row_fetcher (
	input wire clk,
	input wire reset_b,
	input wire dut_run,
	output logic dut_busy,
	output bconv_pkg::addr_t sram_addr,
	input wire bconv_pkg::word_t sram_data,
	output bconv_pkg::addr_t wmem_addr,
	input wire bconv_pkg::word_t wmem_data,
	input wire sweeping,
	input wire writer_idle,
	output bconv_pkg::row_set_t row_set,
	output logic sweep_start,
	output bconv_pkg::col_idx_t col_limit,
	output logic last_image_row,
	output logic kernel_load,
	output bconv_pkg::kernel_t kernel
);

	typedef enum logic [3:0] {
		st_idle, st_rows_addr, st_rows_data, st_cols, st_row0,
		st_row1, st_row2, st_sweep_go, st_sweep_wait, st_drain
	} state_t;

	state_t state;
	bconv_pkg::addr_t ptr;
	bconv_pkg::col_idx_t sweeps_left;
	logic load_q, shift_q;
	bconv_pkg::word_t r0, r1, r2;

	// read address is the pointer itself, data comes back next cycle
	assign sram_addr = ptr;
	// kernel word never moves
	assign wmem_addr = bconv_pkg::weight_addr;
	assign row_set = '{load: load_q, shift: shift_q, row0: r0, row1: r1, row2: r2};

	// ====================
	// control FSM
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= st_idle;
			dut_busy <= 1'b0;
			ptr <= '0;
			sweeps_left <= '0;
			load_q <= 1'b0;
			shift_q <= 1'b0;
			sweep_start <= 1'b0;
			last_image_row <= 1'b0;
			kernel_load <= 1'b0;
		end else begin
			// strobes last one cycle
			load_q <= 1'b0;
			shift_q <= 1'b0;
			sweep_start <= 1'b0;
			kernel_load <= 1'b0;
			case (state)
				st_idle: begin
					// every run starts at the first image
					if (dut_run) begin
						dut_busy <= 1'b1;
						ptr <= '0;
						state <= st_rows_addr;
					end
				end
				st_rows_addr: begin
					ptr <= ptr + 1'b1;
					state <= st_rows_data;
				end
				st_rows_data: begin
					if (sram_data == bconv_pkg::end_marker) begin
						state <= st_drain;
					end else begin
						// rows-2 sweeps per image
						sweeps_left <= bconv_pkg::col_idx_t'(sram_data - bconv_pkg::word_t'(2));
						ptr <= ptr + 1'b1;
						state <= st_cols;
					end
				end
				st_cols: begin
					kernel_load <= 1'b1;
					ptr <= ptr + 1'b1;
					state <= st_row0;
				end
				st_row0: begin
					ptr <= ptr + 1'b1;
					state <= st_row1;
				end
				st_row1: begin
					ptr <= ptr + 1'b1;
					state <= st_row2;
				end
				st_row2: begin
					// ptr already sits on the fourth row
					load_q <= 1'b1;
					state <= st_sweep_go;
				end
				st_sweep_go: begin
					sweep_start <= 1'b1;
					last_image_row <= (sweeps_left == 4'd1);
					sweeps_left <= sweeps_left - 1'b1;
					state <= st_sweep_wait;
				end
				st_sweep_wait: begin
					// rows stay put until the buffer is done sweeping
					if (!sweeping) begin
						if (sweeps_left == '0) begin
							state <= st_rows_addr;
						end else begin
							shift_q <= 1'b1;
							ptr <= ptr + 1'b1;
							state <= st_sweep_go;
						end
					end
				end
				st_drain: begin
					// last row must have left the writer
					if (writer_idle) begin
						dut_busy <= 1'b0;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// ====================
	// geometry, kernel and row capture
	always_ff @(posedge clk) begin
		case (state)
			st_cols: begin
				col_limit <= bconv_pkg::col_idx_t'(sram_data - bconv_pkg::word_t'(2));
				kernel <= bconv_pkg::kernel_t'(wmem_data);
			end
			st_row0: r0 <= sram_data;
			st_row1: r1 <= sram_data;
			st_row2: r2 <= sram_data;
			st_sweep_wait: begin
				// new bottom row for the shift
				if (!sweeping) begin
					r2 <= sram_data;
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/window_buffer.sv */
// three-row line buffer that sweeps the stored rows out to the matcher one column per cycle
`timescale 1ns/10ps
`default_nettype none

module window_buffer (
	input wire clk,
	input wire reset_b,
	input wire bconv_pkg::row_set_t row_set,
	input wire sweep_start,
	input wire bconv_pkg::col_idx_t col_limit,
	input wire last_image_row,
	output logic sweeping,
	output bconv_pkg::window_col_t column
);

	bconv_pkg::word_t b0, b1, b2;
	bconv_pkg::col_idx_t cnt;
	bconv_pkg::col_idx_t issue_idx;
	bconv_pkg::col_idx_t last_col;
	logic active;

	// registered column fields
	logic col_valid;
	logic [2:0] col_bits;
	bconv_pkg::col_idx_t col_idx;
	logic col_last;
	logic col_flush;

	// cols-1
	assign last_col = col_limit + 4'd1;
	// first column issues on the start pulse itself
	assign issue_idx = sweep_start ? '0 : cnt;
	assign sweeping = sweep_start | active;
	assign column = '{valid: col_valid, bits: col_bits, col: col_idx, last: col_last,
		flush: col_flush};

	// ====================
	// column counter
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			active <= 1'b0;
			cnt <= '0;
			col_valid <= 1'b0;
		end else begin
			col_valid <= sweep_start | active;
			if (sweep_start) begin
				active <= 1'b1;
				cnt <= 4'd1;
			end else if (active) begin
				// stop once the last column goes out
				active <= (cnt != last_col);
				cnt <= cnt + 4'd1;
			end
		end
	end

	// ====================
	// row storage and column data
	always_ff @(posedge clk) begin
		if (row_set.load) begin
			b0 <= row_set.row0;
			b1 <= row_set.row1;
			b2 <= row_set.row2;
		end else if (row_set.shift) begin
			// move up one row
			b0 <= b1;
			b1 <= b2;
			b2 <= row_set.row2;
		end
		col_bits <= {b2[issue_idx], b1[issue_idx], b0[issue_idx]};
		col_idx <= issue_idx;
		col_last <= (issue_idx == last_col);
		// fetcher holds last_image_row steady for the whole sweep
		col_flush <= last_image_row;
	end

endmodule

`default_nettype wire

/* verilog/window_matcher.sv */
// 3x3 window against the kernel, counts matching bits and votes one output bit per window
`timescale 1ns/10ps
`default_nettype none

module window_matcher (
	input wire clk,
	input wire reset_b,
	input wire bconv_pkg::window_col_t column,
	input wire bconv_pkg::col_idx_t col_limit,
	input wire kernel_load,
	input wire bconv_pkg::kernel_t kernel,
	output bconv_pkg::vote_t vote
);

	localparam int ks = bconv_pkg::kernel_size;

	bconv_pkg::kernel_t kern_q;
	// win[j][i] is window column j, row i
	logic [ks-1:0][ks-1:0] win;
	// match[i][j] is row i, column j
	logic [ks-1:0][ks-1:0] match;
	logic armed;

	// stage tags
	logic s0_valid, s1_valid, v_valid;
	bconv_pkg::col_idx_t s0_col, s1_col, v_col;
	logic s0_end, s1_end, v_end;
	logic [ks-1:0][1:0] s1_sum;
	logic [3:0] total;
	logic v_hit;

	assign vote = '{valid: v_valid, hit: v_hit, col: v_col, row_end: v_end};

	// xnor against weight bit 3i+j
	always_comb begin
		for (int i = 0; i < ks; i++) begin
			for (int j = 0; j < ks; j++) begin
				match[i][j] = win[j][i] ~^ kern_q[ks * i + j];
			end
		end
	end

	assign total = {2'b00, s1_sum[0]} + {2'b00, s1_sum[1]} + {2'b00, s1_sum[2]};

	// ====================
	// valid pipe
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			armed <= 1'b0;
			s0_valid <= 1'b0;
			s1_valid <= 1'b0;
			v_valid <= 1'b0;
		end else begin
			// kernel good until the image's final column
			if (kernel_load) begin
				armed <= 1'b1;
			end else if (column.valid && column.last && column.flush) begin
				armed <= 1'b0;
			end
			// window complete once column 2 is in
			s0_valid <= column.valid && armed && (column.col >= 4'd2) &&
				(bconv_pkg::col_idx_t'(column.col - 4'd2) < col_limit);
			s1_valid <= s0_valid;
			v_valid <= s1_valid;
		end
	end

	// ====================
	// window, adders and tags
	always_ff @(posedge clk) begin
		if (kernel_load) begin
			kern_q <= kernel;
		end
		if (column.valid) begin
			win <= {column.bits, win[2], win[1]};
		end
		// tag is the leftmost window column
		s0_col <= column.col - 4'd2;
		s0_end <= column.last;
		// stage 1 per-row counts
		for (int i = 0; i < ks; i++) begin
			s1_sum[i] <= {1'b0, match[i][0]} + {1'b0, match[i][1]} + {1'b0, match[i][2]};
		end
		s1_col <= s0_col;
		s1_end <= s0_end;
		// stage 2 total and threshold
		v_hit <= (total >= 4'(bconv_pkg::match_threshold));
		v_col <= s1_col;
		v_end <= s1_end;
	end

endmodule

`default_nettype wire

/* verilog/row_writer.sv */
// collects vote bits into an output row word and writes it out at consecutive addresses
`timescale 1ns/10ps
`default_nettype none

module row_writer (
	input wire clk,
	input wire reset_b,
	input wire bconv_pkg::vote_t vote,
	output logic idle,
	output bconv_pkg::sram_write_t write
);

	bconv_pkg::word_t acc;
	bconv_pkg::word_t acc_next;
	bconv_pkg::word_t wr_data;
	bconv_pkg::addr_t out_addr;
	logic pending;
	logic wr_en;

	// address advances the cycle after each write
	assign write = '{enable: wr_en, address: out_addr, data: wr_data};
	// nothing assembled, arriving or leaving
	assign idle = !pending && !vote.valid && !wr_en;

	always_comb begin
		acc_next = acc;
		acc_next[vote.col] = vote.hit;
	end

	// ====================
	// accumulator and address
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			acc <= '0;
			pending <= 1'b0;
			wr_en <= 1'b0;
			out_addr <= '0;
		end else begin
			wr_en <= 1'b0;
			if (wr_en) begin
				// counter spans all images and runs
				out_addr <= out_addr + 1'b1;
			end
			if (vote.valid) begin
				if (vote.row_end) begin
					// start the next row clean
					acc <= '0;
					pending <= 1'b0;
					wr_en <= 1'b1;
				end else begin
					acc <= acc_next;
					pending <= 1'b1;
				end
			end
		end
	end

	// finished row word
	always_ff @(posedge clk) begin
		if (vote.valid && vote.row_end) begin
			wr_data <= acc_next;
		end
	end

endmodule

`default_nettype wire

/* verilog/bconv_top.sv */
// top level of the 3x3 binary convolution engine, connects to the input, weight and output memories
`timescale 1ns/10ps
`default_nettype none

module bconv_top (
	input wire clk,
	input wire reset_b,
	input wire dut_run,
	output logic dut_busy,
	output bconv_pkg::addr_t dut_sram_read_address,
	input wire bconv_pkg::word_t sram_dut_read_data,
	output bconv_pkg::addr_t dut_wmem_read_address,
	input wire bconv_pkg::word_t wmem_dut_read_data,
	output bconv_pkg::addr_t dut_sram_write_address,
	output bconv_pkg::word_t dut_sram_write_data,
	output logic dut_sram_write_enable
);

	// fetcher to buffer
	bconv_pkg::row_set_t row_set;
	logic sweep_start;
	logic last_image_row;
	bconv_pkg::col_idx_t col_limit;
	logic sweeping;

	// fetcher to matcher
	logic kernel_load;
	bconv_pkg::kernel_t kernel;

	// buffer to matcher, matcher to writer
	bconv_pkg::window_col_t column;
	bconv_pkg::vote_t vote;

	// writer back to fetcher and out
	logic writer_idle;
	bconv_pkg::sram_write_t write;

	row_fetcher u_fetcher (
		.clk(clk), .reset_b(reset_b), .dut_run(dut_run), .dut_busy(dut_busy),
		.sram_addr(dut_sram_read_address), .sram_data(sram_dut_read_data),
		.wmem_addr(dut_wmem_read_address), .wmem_data(wmem_dut_read_data),
		.sweeping(sweeping), .writer_idle(writer_idle), .row_set(row_set),
		.sweep_start(sweep_start), .col_limit(col_limit), .last_image_row(last_image_row),
		.kernel_load(kernel_load), .kernel(kernel)
	);

	window_buffer u_buffer (
		.clk(clk), .reset_b(reset_b), .row_set(row_set), .sweep_start(sweep_start),
		.col_limit(col_limit), .last_image_row(last_image_row), .sweeping(sweeping),
		.column(column)
	);

	window_matcher u_matcher (
		.clk(clk), .reset_b(reset_b), .column(column), .col_limit(col_limit),
		.kernel_load(kernel_load), .kernel(kernel), .vote(vote)
	);

	row_writer u_writer (
		.clk(clk), .reset_b(reset_b), .vote(vote), .idle(writer_idle), .write(write)
	);

	// flat output memory port
	assign dut_sram_write_enable = write.enable;
	assign dut_sram_write_address = write.address;
	assign dut_sram_write_data = write.data;

endmodule

`default_nettype wire

/* verification/bconv_properties.sv */
// write and busy protocol assertions, bound onto the engine top level
`timescale 1ns/10ps
`default_nettype none

module bconv_properties (
	input wire clk,
	input wire reset_b,
	input wire dut_busy,
	input wire dut_sram_write_enable,
	input wire bconv_pkg::addr_t dut_sram_read_address,
	input wire bconv_pkg::addr_t dut_wmem_read_address
);

	// ====================
	// write pulse is one cycle wide
	write_single_cycle: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |=> !dut_sram_write_enable)
		else $error("write enable high on two cycles in a row");

	// writes only inside a run
	write_while_busy: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |-> dut_busy)
		else $error("write enable high while dut_busy is low");

	// read addresses driven during a run
	read_address_known: assert property (@(posedge clk) disable iff (!reset_b)
		dut_busy |-> !$isunknown({dut_sram_read_address, dut_wmem_read_address}))
		else $error("read address unknown while dut_busy is high");

endmodule

`default_nettype wire

/* verification/bconv_tb.sv */
// testbench for the 3x3 binary convolution engine, random images checked against a reference model
`timescale 1ns/10ps
`default_nettype none

module bconv_tb;

	logic clk;
	logic reset_b;
	logic dut_run;
	logic dut_busy;
	bconv_pkg::addr_t dut_sram_read_address;
	bconv_pkg::word_t sram_dut_read_data = '0;
	bconv_pkg::addr_t dut_wmem_read_address;
	bconv_pkg::word_t wmem_dut_read_data = '0;
	bconv_pkg::addr_t dut_sram_write_address;
	bconv_pkg::word_t dut_sram_write_data;
	logic dut_sram_write_enable;

	// memory models, captured writes in arrival order
	bconv_pkg::word_t sram_mem [0:4095];
	bconv_pkg::word_t wmem [0:4095];
	bconv_pkg::addr_t wr_addr_q [$];
	bconv_pkg::word_t wr_data_q [$];

	int seed = 32'h32f7f2b2;
	int check_count = 0;
	int error_count = 0;
	// output address expected for the next write
	int next_addr = 0;
	// watchdog
	int cycle_count = 0;
	int deadline = 1000;

	bconv_top uut (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.dut_busy(dut_busy),
		.dut_sram_read_address(dut_sram_read_address),
		.sram_dut_read_data(sram_dut_read_data),
		.dut_wmem_read_address(dut_wmem_read_address),
		.wmem_dut_read_data(wmem_dut_read_data),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable)
	);

	bind bconv_top bconv_properties u_properties (
		.clk(clk),
		.reset_b(reset_b),
		.dut_busy(dut_busy),
		.dut_sram_write_enable(dut_sram_write_enable),
		.dut_sram_read_address(dut_sram_read_address),
		.dut_wmem_read_address(dut_wmem_read_address)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// ====================
	// memories, one cycle read latency
	always @(posedge clk) begin
		sram_dut_read_data <= sram_mem[dut_sram_read_address];
		wmem_dut_read_data <= wmem[dut_wmem_read_address];
		if (dut_sram_write_enable) begin
			wr_addr_q.push_back(dut_sram_write_address);
			wr_data_q.push_back(dut_sram_write_data);
		end
	end

	// cycle limit per run, moved on at every run start
	initial begin
		while (cycle_count <= deadline) begin
			@(negedge clk);
			cycle_count++;
		end
		$display("timeout: dut_busy did not fall within the cycle limit");
		$display("checks: %0d, errors: %0d", check_count, error_count);
		$display("Testbench failed");
		$finish;
	end

	// ====================
	task automatic check_value(input string name, input int expected, input int actual);
		check_count++;
		assert (expected == actual) else begin
			error_count++;
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// 3 to 16
	function automatic int random_dim();
		return 3 + int'($unsigned($random(seed)) % 14);
	endfunction

	// header words then one random word per row, upper bits left random
	task automatic put_image(inout int ptr, input int rows_n, input int cols_n);
		sram_mem[12'(ptr)] = bconv_pkg::word_t'(rows_n);
		sram_mem[12'(ptr + 1)] = bconv_pkg::word_t'(cols_n);
		for (int r = 0; r < rows_n; r++) begin
			sram_mem[12'(ptr + 2 + r)] = bconv_pkg::word_t'($random(seed));
		end
		ptr += rows_n + 2;
	endtask

	// reference output row r of the image at base
	function automatic bconv_pkg::word_t expected_row(input int base, input int r,
		input bconv_pkg::kernel_t k);
		int cols_n;
		int agree;
		bconv_pkg::word_t line;
		bconv_pkg::word_t result;
		result = '0;
		cols_n = int'(sram_mem[12'(base + 1)]);
		for (int c = 0; c <= cols_n - 3; c++) begin
			agree = 0;
			for (int i = 0; i < 3; i++) begin
				line = sram_mem[12'(base + 2 + r + i)];
				// weight bit 3i+j against row r+i, column c+j
				for (int j = 0; j < 3; j++) begin
					if (line[4'(c + j)] == k[4'(3 * i + j)]) begin
						agree++;
					end
				end
			end
			result[4'(c)] = (agree >= 5);
		end
		return result;
	endfunction

	// one pulse of dut_run, wait for the end of the run, compare every write
	task automatic run_pass(input string name);
		bconv_pkg::word_t exp_q [$];
		bconv_pkg::kernel_t k;
		int base;
		int rows_n;
		int cols_n;
		int limit;
		int first;
		k = bconv_pkg::kernel_t'(wmem[bconv_pkg::weight_addr]);
		base = 0;
		limit = 0;
		while (sram_mem[12'(base)] != bconv_pkg::end_marker) begin
			rows_n = int'(sram_mem[12'(base)]);
			cols_n = int'(sram_mem[12'(base + 1)]);
			for (int r = 0; r < rows_n - 2; r++) begin
				exp_q.push_back(expected_row(base, r, k));
			end
			limit += rows_n * (cols_n + 10) + 50;
			base += rows_n + 2;
		end
		first = wr_data_q.size();
		@(posedge clk);
		deadline = cycle_count + 2 * limit + 50;
		dut_run <= 1'b1;
		@(posedge clk);
		dut_run <= 1'b0;
		@(negedge clk);
		// busy one cycle after run is seen
		check_value({name, " busy rise"}, 1, 32'(dut_busy));
		while (dut_busy) begin
			@(negedge clk);
		end
		check_value({name, " write count"}, exp_q.size(), wr_data_q.size() - first);
		for (int i = 0; i < exp_q.size() && first + i < wr_data_q.size(); i++) begin
			check_value($sformatf("%s row %0d address", name, i), next_addr + i,
				32'(wr_addr_q[first + i]));
			check_value($sformatf("%s row %0d data", name, i), 32'(exp_q[i]),
				32'(wr_data_q[first + i]));
		end
		next_addr += exp_q.size();
	endtask

	// ====================
	initial begin
		int ptr;
		reset_b = 1'b0;
		dut_run = 1'b0;
		// background fill, unique per address
		for (int a = 0; a < 4096; a++) begin
			sram_mem[a] = bconv_pkg::word_t'(a * 40503) ^ 16'h5a5a;
			wmem[a] = ~bconv_pkg::word_t'(a * 40503);
		end
		repeat (2) @(posedge clk);
		reset_b <= 1'b1;
		// quiet until the first run
		repeat (3) begin
			@(negedge clk);
			check_value("idle busy", 0, 32'(dut_busy));
			check_value("idle write enable", 0, 32'(dut_sram_write_enable));
		end

		// one random image
		ptr = 0;
		put_image(ptr, random_dim(), random_dim());
		sram_mem[12'(ptr)] = bconv_pkg::end_marker;
		wmem[bconv_pkg::weight_addr] = bconv_pkg::word_t'($random(seed));
		run_pass("single");

		// images back to back, then the same memory once more
		ptr = 0;
		for (int n = 0; n < 5; n++) begin
			put_image(ptr, random_dim(), random_dim());
		end
		sram_mem[12'(ptr)] = bconv_pkg::end_marker;
		wmem[bconv_pkg::weight_addr] = bconv_pkg::word_t'($random(seed));
		run_pass("multi");
		run_pass("multi rerun");

		// smallest and largest sizes, all-ones then all-zeros kernel
		for (int w = 0; w < 2; w++) begin
			ptr = 0;
			put_image(ptr, 3, 3);
			put_image(ptr, 16, 16);
			sram_mem[12'(ptr)] = bconv_pkg::end_marker;
			wmem[bconv_pkg::weight_addr] = (w == 0) ? 16'h01ff : 16'h0000;
			run_pass((w == 0) ? "edge ones" : "edge zeros");
		end

		// end marker first, no writes
		sram_mem[0] = bconv_pkg::end_marker;
		run_pass("empty");

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
verilog/bconv_pkg.sv
verilog/row_fetcher.sv
verilog/window_buffer.sv
verilog/window_matcher.sv
verilog/row_writer.sv
verilog/bconv_top.sv
verification/bconv_properties.sv
verification/bconv_tb.sv

/* Makefile */
TOP = bconv_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and search the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "Testbench failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
